// File: design/i3c_standby_settings.svh
// Widths, addresses and reset values shared by the standby controller RTL and its testbench
`ifndef I3C_STANDBY_SETTINGS_SVH
`define I3C_STANDBY_SETTINGS_SVH

// I3C addressing
`define I3C_ADDR_W 7
`define I3C_BCAST_ADDR 7'h7E

// IBI queue word and descriptor length field
`define I3C_IBI_WORD_W 32
`define I3C_IBI_LEN_W 8

// Max write length after reset
`define I3C_MWL_RESET 16'h0100

// RSTACT defining byte values
`define I3C_RST_ACT_PERIPH 8'h01
`define I3C_RST_ACT_ESCALATE 8'h02

`endif

// File: design/i3c_standby_pkg.sv
// Types for the standby controller, referenced by scoped name from every block and the testbench
package i3c_standby_pkg;

  // One bus event per cycle from the PHY
  typedef struct packed {
    logic       start;
    logic       stop;
    logic       byte_valid;
    logic [7:0] data;
  } bus_evt_t;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } byte_stream_t;

  // Single-cycle CCC result pulses
  typedef struct packed {
    logic enec_int;
    logic disec_int;
    logic enec_hj;
    logic disec_hj;
    logic set_mwl;
    logic rst_act_valid;
  } ccc_evt_t;

  typedef enum logic [1:0] {
    OwnFsm,
    OwnCcc,
    OwnIbi
  } xfer_owner_e;

  typedef enum logic [7:0] {
    CccEnec   = 8'h00,
    CccDisec  = 8'h01,
    CccSetmwl = 8'h09,
    CccRstact = 8'h2A
  } ccc_code_e;

  typedef enum logic [1:0] {
    IbiIdle,
    IbiAddr,
    IbiData,
    IbiDone
  } ibi_state_e;

endpackage

// File: design/frame_decoder.sv
// Frame tracker of the standby target, routes bus bytes to the write path, the CCC path or IBI
`timescale 1ns/1ps
`include "i3c_standby_settings.svh"

module frame_decoder (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  i3c_standby_pkg::bus_evt_t     bus_evt_i,
  input  logic [`I3C_ADDR_W-1:0]        dyn_addr_i,
  input  logic                          ibi_en_i,
  input  logic                          ibi_pending_i,
  input  logic                          ibi_done_i,
  output logic                          ibi_start_o,
  output i3c_standby_pkg::byte_stream_t rx_byte_o,
  output logic                          rx_valid_o,
  output i3c_standby_pkg::ccc_code_e    ccc_code_o,
  output i3c_standby_pkg::byte_stream_t ccc_byte_o,
  output logic                          ccc_valid_o
);

  typedef enum logic [2:0] {
    FrIdle,
    FrAddr,
    FrCode,
    FrData,
    FrSkip
  } frame_state_e;

  frame_state_e                  fr_q;
  i3c_standby_pkg::xfer_owner_e  owner_q;
  logic                          hold_vld_q;
  logic [7:0]                    hold_q;
  i3c_standby_pkg::byte_stream_t out_q;
  logic                          out_rx_q;
  logic                          out_ccc_q;
  i3c_standby_pkg::ccc_code_e    code_q;

  logic bus_owned;
  logic frame_end;
  logic data_byte;
  logic release_byte;
  logic addr_bcast;
  logic addr_own;

  // A START in the same cycle wins over the IBI
  assign ibi_start_o = (owner_q == i3c_standby_pkg::OwnFsm) && (fr_q == FrIdle) &&
                       !bus_evt_i.start && ibi_en_i && ibi_pending_i;

  assign bus_owned    = (owner_q != i3c_standby_pkg::OwnIbi) && !ibi_start_o;
  assign frame_end    = bus_owned && (bus_evt_i.start || bus_evt_i.stop);
  assign data_byte    = bus_owned && bus_evt_i.byte_valid && (fr_q == FrData);
  assign release_byte = hold_vld_q && (frame_end || data_byte);

  // Write requests only, RnW must be 0
  assign addr_bcast = (bus_evt_i.data[7:1] == `I3C_BCAST_ADDR) && !bus_evt_i.data[0];
  assign addr_own   = (bus_evt_i.data[7:1] == dyn_addr_i) && !bus_evt_i.data[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fr_q       <= FrIdle;
      owner_q    <= i3c_standby_pkg::OwnFsm;
      hold_vld_q <= 1'b0;
      out_rx_q   <= 1'b0;
      out_ccc_q  <= 1'b0;
    end else begin
      out_rx_q  <= release_byte && (owner_q == i3c_standby_pkg::OwnFsm);
      out_ccc_q <= release_byte && (owner_q == i3c_standby_pkg::OwnCcc);
      if (ibi_start_o) begin
        owner_q <= i3c_standby_pkg::OwnIbi;
      end else if (owner_q == i3c_standby_pkg::OwnIbi) begin
        if (ibi_done_i) owner_q <= i3c_standby_pkg::OwnFsm;
      end else if (bus_evt_i.start) begin
        fr_q       <= FrAddr;
        hold_vld_q <= 1'b0;
      end else if (bus_evt_i.stop) begin
        fr_q       <= FrIdle;
        owner_q    <= i3c_standby_pkg::OwnFsm;
        hold_vld_q <= 1'b0;
      end else if (bus_evt_i.byte_valid) begin
        case (fr_q)
          FrAddr: begin
            if (addr_bcast) begin
              owner_q <= i3c_standby_pkg::OwnCcc;
              fr_q    <= FrCode;
            end else begin
              owner_q <= i3c_standby_pkg::OwnFsm;
              fr_q    <= addr_own ? FrData : FrSkip;
            end
          end
          FrCode:  fr_q <= FrData;
          FrData:  hold_vld_q <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  // Held byte goes out with last set when the frame ends behind it
  always_ff @(posedge clk_i) begin
    if (release_byte) begin
      out_q.data <= hold_q;
      out_q.last <= frame_end;
    end
    if (data_byte) hold_q <= bus_evt_i.data;
    if (bus_owned && bus_evt_i.byte_valid && (fr_q == FrCode)) begin
      code_q <= i3c_standby_pkg::ccc_code_e'(bus_evt_i.data);
    end
  end

  assign rx_byte_o   = out_q;
  assign rx_valid_o  = out_rx_q;
  assign ccc_byte_o  = out_q;
  assign ccc_valid_o = out_ccc_q;
  assign ccc_code_o  = code_q;

endmodule

// File: design/ccc_decoder.sv
// Broadcast CCC decoder holding the event enables and max write length, fed by the frame decoder
`timescale 1ns/1ps
`include "i3c_standby_settings.svh"

module ccc_decoder (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  i3c_standby_pkg::ccc_code_e    ccc_code_i,
  input  i3c_standby_pkg::byte_stream_t ccc_byte_i,
  input  logic                          ccc_valid_i,
  output i3c_standby_pkg::ccc_evt_t     ccc_evt_o,
  output logic                          ibi_en_o,
  output logic                          hj_en_o,
  output logic [15:0]                   mwl_o,
  output logic [7:0]                    rst_action_o
);

  // Event bits of the ENEC/DISEC defining byte
  localparam int IntBit = 0;
  localparam int HjBit  = 3;

  logic [1:0] cnt_q;
  logic [7:0] mwl_msb_q;
  logic       first_byte;

  assign first_byte = (cnt_q == 2'd0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q        <= 2'd0;
      ccc_evt_o    <= '0;
      ibi_en_o     <= 1'b1;
      hj_en_o      <= 1'b1;
      mwl_o        <= `I3C_MWL_RESET;
      rst_action_o <= 8'h00;
    end else begin
      ccc_evt_o <= '0;
      if (ccc_valid_i) begin
        if (ccc_byte_i.last) cnt_q <= 2'd0;
        else if (cnt_q != 2'd3) cnt_q <= cnt_q + 2'd1;
        case (ccc_code_i)
          i3c_standby_pkg::CccEnec: begin
            if (first_byte) begin
              if (ccc_byte_i.data[IntBit]) ibi_en_o <= 1'b1;
              if (ccc_byte_i.data[HjBit]) hj_en_o <= 1'b1;
              ccc_evt_o.enec_int <= ccc_byte_i.data[IntBit];
              ccc_evt_o.enec_hj  <= ccc_byte_i.data[HjBit];
            end
          end
          i3c_standby_pkg::CccDisec: begin
            if (first_byte) begin
              if (ccc_byte_i.data[IntBit]) ibi_en_o <= 1'b0;
              if (ccc_byte_i.data[HjBit]) hj_en_o <= 1'b0;
              ccc_evt_o.disec_int <= ccc_byte_i.data[IntBit];
              ccc_evt_o.disec_hj  <= ccc_byte_i.data[HjBit];
            end
          end
          i3c_standby_pkg::CccRstact: begin
            if (first_byte) begin
              rst_action_o            <= ccc_byte_i.data;
              ccc_evt_o.rst_act_valid <= 1'b1;
            end
          end
          // MSB arrives first, the second byte completes the command
          i3c_standby_pkg::CccSetmwl: begin
            if (cnt_q == 2'd1) begin
              mwl_o             <= {mwl_msb_q, ccc_byte_i.data};
              ccc_evt_o.set_mwl <= 1'b1;
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ccc_valid_i && (ccc_code_i == i3c_standby_pkg::CccSetmwl) && first_byte) begin
      mwl_msb_q <= ccc_byte_i.data;
    end
  end

endmodule

// File: design/ibi_engine.sv
// IBI sender that turns queued descriptor and payload words into an address byte and payload bytes
`timescale 1ns/1ps
`include "i3c_standby_settings.svh"

module ibi_engine (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start_i,
  output logic                          done_o,
  input  logic [`I3C_ADDR_W-1:0]        ibi_addr_i,
  input  logic [`I3C_IBI_WORD_W-1:0]    ibi_word_i,
  input  logic                          ibi_valid_i,
  output logic                          ibi_ready_o,
  output i3c_standby_pkg::byte_stream_t tx_byte_o,
  output logic                          tx_valid_o,
  input  logic                          tx_ready_i
);

  localparam int BytesPerWord = `I3C_IBI_WORD_W / 8;
  localparam int CntW         = $clog2(BytesPerWord + 1);

  i3c_standby_pkg::ibi_state_e state_q;
  logic [`I3C_IBI_LEN_W-1:0]   rem_q;
  logic [`I3C_IBI_WORD_W-1:0]  sr_q;
  logic [CntW-1:0]             sr_cnt_q;
  logic                        pop;
  logic                        tx_fire;

  // Descriptor pops in the start cycle, payload words only into an empty shift register
  always_comb begin
    ibi_ready_o = 1'b0;
    tx_valid_o  = 1'b0;
    tx_byte_o   = '0;
    case (state_q)
      i3c_standby_pkg::IbiIdle: ibi_ready_o = start_i;
      i3c_standby_pkg::IbiAddr: begin
        tx_valid_o     = 1'b1;
        tx_byte_o.data = {ibi_addr_i, 1'b1};
        tx_byte_o.last = (rem_q == '0);
      end
      i3c_standby_pkg::IbiData: begin
        if (sr_cnt_q == '0) begin
          ibi_ready_o = 1'b1;
        end else begin
          tx_valid_o     = 1'b1;
          tx_byte_o.data = sr_q[7:0];
          tx_byte_o.last = (rem_q == 'd1);
        end
      end
      default: ;
    endcase
  end

  assign pop     = ibi_ready_o && ibi_valid_i;
  assign tx_fire = tx_valid_o && tx_ready_i;
  assign done_o  = (state_q == i3c_standby_pkg::IbiDone);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= i3c_standby_pkg::IbiIdle;
      sr_cnt_q <= '0;
    end else begin
      case (state_q)
        i3c_standby_pkg::IbiIdle: if (pop) state_q <= i3c_standby_pkg::IbiAddr;
        i3c_standby_pkg::IbiAddr: begin
          if (tx_fire) begin
            state_q <= (rem_q == '0) ? i3c_standby_pkg::IbiDone : i3c_standby_pkg::IbiData;
          end
        end
        i3c_standby_pkg::IbiData: begin
          if (pop) begin
            sr_cnt_q <= CntW'(BytesPerWord);
          end else if (tx_fire) begin
            sr_cnt_q <= sr_cnt_q - 1'b1;
            // Unused bytes of the final word are dropped
            if (rem_q == 'd1) begin
              state_q  <= i3c_standby_pkg::IbiDone;
              sr_cnt_q <= '0;
            end
          end
        end
        default: state_q <= i3c_standby_pkg::IbiIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop && (state_q == i3c_standby_pkg::IbiIdle)) rem_q <= ibi_word_i[`I3C_IBI_LEN_W-1:0];
    if (pop && (state_q == i3c_standby_pkg::IbiData)) sr_q <= ibi_word_i;
    if (tx_fire && (state_q == i3c_standby_pkg::IbiData)) begin
      rem_q <= rem_q - 1'b1;
      sr_q  <= sr_q >> 8;
    end
  end

endmodule

// File: design/reset_action.sv
// Peripheral and escalated reset requests from RSTACT commands and target reset patterns
`timescale 1ns/1ps
`include "i3c_standby_settings.svh"

module reset_action (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [7:0] rst_action_i,
  input  logic       rst_act_valid_i,
  input  logic       reset_pattern_i,
  input  logic       peripheral_reset_done_i,
  output logic       peripheral_reset_o,
  output logic       escalated_reset_o
);

  logic pattern_seen_q;
  logic periph_set;
  logic escal_set;

  // Second pattern escalates
  assign periph_set = (rst_act_valid_i && (rst_action_i == `I3C_RST_ACT_PERIPH)) ||
                      (reset_pattern_i && !pattern_seen_q);
  assign escal_set  = (rst_act_valid_i && (rst_action_i == `I3C_RST_ACT_ESCALATE)) ||
                      (reset_pattern_i && pattern_seen_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pattern_seen_q     <= 1'b0;
      peripheral_reset_o <= 1'b0;
      escalated_reset_o  <= 1'b0;
    end else begin
      if (reset_pattern_i) pattern_seen_q <= 1'b1;
      if (periph_set) peripheral_reset_o <= 1'b1;
      if (peripheral_reset_done_i) peripheral_reset_o <= 1'b0;
      if (escal_set) escalated_reset_o <= 1'b1;
    end
  end

endmodule

// File: design/i3c_standby_ctrl.sv
// Top level of the I3C target standby controller, connects frame, CCC, IBI and reset blocks
`timescale 1ns/1ps
`include "i3c_standby_settings.svh"

module i3c_standby_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  i3c_standby_pkg::bus_evt_t     bus_evt_i,
  input  logic                          target_reset_pattern_i,
  input  logic [`I3C_ADDR_W-1:0]        dyn_addr_i,
  input  logic [`I3C_ADDR_W-1:0]        ibi_addr_i,
  input  logic [`I3C_IBI_WORD_W-1:0]    ibi_word_i,
  input  logic                          ibi_valid_i,
  output logic                          ibi_ready_o,
  output i3c_standby_pkg::byte_stream_t tx_byte_o,
  output logic                          tx_valid_o,
  input  logic                          tx_ready_i,
  output i3c_standby_pkg::byte_stream_t rx_byte_o,
  output logic                          rx_valid_o,
  output i3c_standby_pkg::ccc_evt_t     ccc_evt_o,
  output logic                          ibi_en_o,
  output logic                          hj_en_o,
  output logic [15:0]                   mwl_o,
  output logic [7:0]                    rst_action_o,
  input  logic                          peripheral_reset_done_i,
  output logic                          peripheral_reset_o,
  output logic                          escalated_reset_o
);

  i3c_standby_pkg::ccc_code_e    ccc_code;
  i3c_standby_pkg::byte_stream_t ccc_byte;
  logic                          ccc_valid;
  logic                          ibi_start;
  logic                          ibi_done;

  // A queued word means an IBI is pending
  frame_decoder u_frame_decoder (
    .clk_i,
    .rst_ni,
    .bus_evt_i,
    .dyn_addr_i,
    .ibi_en_i      (ibi_en_o),
    .ibi_pending_i (ibi_valid_i),
    .ibi_done_i    (ibi_done),
    .ibi_start_o   (ibi_start),
    .rx_byte_o,
    .rx_valid_o,
    .ccc_code_o    (ccc_code),
    .ccc_byte_o    (ccc_byte),
    .ccc_valid_o   (ccc_valid)
  );

  ccc_decoder u_ccc_decoder (
    .clk_i,
    .rst_ni,
    .ccc_code_i  (ccc_code),
    .ccc_byte_i  (ccc_byte),
    .ccc_valid_i (ccc_valid),
    .ccc_evt_o,
    .ibi_en_o,
    .hj_en_o,
    .mwl_o,
    .rst_action_o
  );

  ibi_engine u_ibi_engine (
    .clk_i,
    .rst_ni,
    .start_i (ibi_start),
    .done_o  (ibi_done),
    .ibi_addr_i,
    .ibi_word_i,
    .ibi_valid_i,
    .ibi_ready_o,
    .tx_byte_o,
    .tx_valid_o,
    .tx_ready_i
  );

  reset_action u_reset_action (
    .clk_i,
    .rst_ni,
    .rst_action_i            (rst_action_o),
    .rst_act_valid_i         (ccc_evt_o.rst_act_valid),
    .reset_pattern_i         (target_reset_pattern_i),
    .peripheral_reset_done_i,
    .peripheral_reset_o,
    .escalated_reset_o
  );

endmodule

// File: verification/tb_i3c_standby_ctrl.sv
// Self-checking testbench for the standby controller, run from the file list with uut as the DUT
`timescale 1ns/1ps
`include "i3c_standby_settings.svh"

module tb_i3c_standby_ctrl;

  // CCC pulse together with the register values expected after it
  typedef struct packed {
    i3c_standby_pkg::ccc_evt_t evt;
    logic                      ibi_en;
    logic                      hj_en;
    logic [15:0]               mwl;
  } ccc_exp_t;

  localparam logic [6:0] DynAddr = 7'h2C;
  localparam logic [6:0] OtherAddr = 7'h11;
  localparam int Timeout = 3000;

  logic                          clk_i;
  logic                          rst_ni;
  i3c_standby_pkg::bus_evt_t     bus_evt_i;
  logic                          target_reset_pattern_i;
  logic [`I3C_ADDR_W-1:0]        dyn_addr_i;
  logic [`I3C_ADDR_W-1:0]        ibi_addr_i;
  logic [`I3C_IBI_WORD_W-1:0]    ibi_word_i;
  logic                          ibi_valid_i;
  logic                          ibi_ready_o;
  i3c_standby_pkg::byte_stream_t tx_byte_o;
  logic                          tx_valid_o;
  logic                          tx_ready_i;
  i3c_standby_pkg::byte_stream_t rx_byte_o;
  logic                          rx_valid_o;
  i3c_standby_pkg::ccc_evt_t     ccc_evt_o;
  logic                          ibi_en_o;
  logic                          hj_en_o;
  logic [15:0]                   mwl_o;
  logic [7:0]                    rst_action_o;
  logic                          peripheral_reset_done_i;
  logic                          peripheral_reset_o;
  logic                          escalated_reset_o;

  logic [31:0] lfsr_q;
  int          errors;
  logic [31:0] ibi_q[$];
  logic [8:0]  exp_rx[$];
  logic [8:0]  exp_tx[$];
  ccc_exp_t    exp_ccc[$];
  ccc_exp_t    model;
  ccc_exp_t    cur;
  logic        gate_ibi;
  logic        stall_q;
  logic [8:0]  stall_byte_q;
  int          k;

  i3c_standby_ctrl uut (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic report_failure(input string what);
    errors++;
    $display("%0t: %s", $time, what);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (exp === got) else begin
      errors++;
      $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  // Scoreboard compare of every output, sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (rx_valid_o) begin
        assert (exp_rx.size() != 0) else report_failure("private write byte with none expected");
        if (exp_rx.size() != 0) check_value("rx_byte_o", exp_rx.pop_front(), rx_byte_o);
      end
      if (stall_q) begin
        assert (tx_valid_o) else report_failure("tx_valid_o dropped while stalled");
        check_value("tx_byte_o (stalled)", stall_byte_q, tx_byte_o);
      end
      if (tx_valid_o && tx_ready_i) begin
        assert (exp_tx.size() != 0) else report_failure("IBI byte with none expected");
        if (exp_tx.size() != 0) check_value("tx_byte_o", exp_tx.pop_front(), tx_byte_o);
      end
      stall_q = tx_valid_o && !tx_ready_i;
      stall_byte_q = tx_byte_o;
      if (gate_ibi) begin
        assert (!tx_valid_o && !ibi_ready_o) else report_failure("IBI activity while blocked");
      end
      if (ccc_evt_o != '0) begin
        assert (exp_ccc.size() != 0) else report_failure("CCC event with none expected");
        if (exp_ccc.size() != 0) begin
          cur = exp_ccc.pop_front();
          check_value("ccc_evt_o", cur.evt, ccc_evt_o);
        end
      end
      check_value("ibi_en_o", cur.ibi_en, ibi_en_o);
      check_value("hj_en_o", cur.hj_en, hj_en_o);
      check_value("mwl_o", cur.mwl, mwl_o);
    end else begin
      stall_q = 1'b0;
    end
  end

  // IBI queue source and random TX back-pressure
  always @(posedge clk_i) begin
    if (rst_ni && ibi_valid_i && ibi_ready_o) ibi_q.delete(0);
    ibi_valid_i <= (ibi_q.size() != 0);
    ibi_word_i  <= (ibi_q.size() != 0) ? ibi_q[0] : '0;
    tx_ready_i  <= (rand_bits(2) != 0);
  end

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    model = '{evt: '0, ibi_en: 1'b1, hj_en: 1'b1, mwl: `I3C_MWL_RESET};
    cur = model;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("tx_valid_o", 0, tx_valid_o);
    check_value("rx_valid_o", 0, rx_valid_o);
    check_value("ibi_ready_o", 0, ibi_ready_o);
    check_value("ccc_evt_o", 0, ccc_evt_o);
    check_value("peripheral_reset_o", 0, peripheral_reset_o);
    check_value("escalated_reset_o", 0, escalated_reset_o);
  endtask

  task automatic bus_event(input logic s, input logic p, input logic v, input logic [7:0] d);
    @(posedge clk_i);
    bus_evt_i <= {s, p, v, d};
    @(posedge clk_i);
    bus_evt_i <= '0;
  endtask

  task automatic send_start();
    bus_event(1'b1, 1'b0, 1'b0, 8'h00);
  endtask

  task automatic send_byte(input logic [7:0] d);
    bus_event(1'b0, 1'b0, 1'b1, d);
  endtask

  task automatic send_stop();
    bus_event(1'b0, 1'b1, 1'b0, 8'h00);
  endtask

  task automatic queue_ibi(input int n);
    logic [31:0] w;
    logic [7:0]  b;
    int          i;
    @(negedge clk_i);
    w = rand_bits(24);
    ibi_q.push_back({w[23:0], 8'(n)});
    exp_tx.push_back({ibi_addr_i, 1'b1, n == 0});
    for (i = 0; i < n; i++) begin
      if (i % 4 == 0) w = rand_bits(32);
      b = rand_bits(8);
      w[8*(i%4) +: 8] = b;
      exp_tx.push_back({b, i == n - 1});
      if (i % 4 == 3 || i == n - 1) ibi_q.push_back(w);
    end
  endtask

  task automatic wait_ibi();
    int t;
    for (t = 0; t < Timeout && (exp_tx.size() != 0 || ibi_q.size() != 0); t++) begin
      @(negedge clk_i);
    end
    assert (exp_tx.size() == 0 && ibi_q.size() == 0)
      else report_failure("timeout waiting for the IBI to finish");
    // Room for done and the owner hand-back
    repeat (3) @(negedge clk_i);
  endtask

  task automatic wait_rx();
    int t;
    for (t = 0; t < Timeout && exp_rx.size() != 0; t++) @(negedge clk_i);
    assert (exp_rx.size() == 0) else report_failure("timeout waiting for private write bytes");
  endtask

  task automatic private_write(input logic [6:0] addr, input int n, input logic with_ibi);
    logic [7:0] b;
    int         i;
    send_start();
    send_byte({addr, 1'b0});
    if (with_ibi) begin
      gate_ibi = 1'b1;
      queue_ibi(2);
    end
    for (i = 0; i < n; i++) begin
      b = 8'(i * 37 + 5);
      if (addr == dyn_addr_i) exp_rx.push_back({b, i == n - 1});
      send_byte(b);
    end
    gate_ibi = 1'b0;
    send_stop();
  endtask

  task automatic send_ccc(input ccc_exp_t e, input logic [7:0] code, input logic [7:0] b0,
                          input logic [7:0] b1, input logic two);
    int t;
    model = e;
    exp_ccc.push_back(e);
    send_start();
    send_byte({`I3C_BCAST_ADDR, 1'b0});
    send_byte(code);
    send_byte(b0);
    if (two) send_byte(b1);
    send_stop();
    for (t = 0; t < Timeout && exp_ccc.size() != 0; t++) @(negedge clk_i);
    assert (exp_ccc.size() == 0) else report_failure("timeout waiting for a CCC event");
  endtask

  // ENEC when en is set, DISEC otherwise
  task automatic enec_disec(input logic en, input logic [7:0] b);
    ccc_exp_t e;
    e = model;
    e.evt = '0;
    if (b[0]) e.ibi_en = en;
    if (b[3]) e.hj_en = en;
    e.evt.enec_int  = en & b[0];
    e.evt.enec_hj   = en & b[3];
    e.evt.disec_int = !en & b[0];
    e.evt.disec_hj  = !en & b[3];
    send_ccc(e, en ? i3c_standby_pkg::CccEnec : i3c_standby_pkg::CccDisec, b, 8'h00, 1'b0);
  endtask

  task automatic setmwl(input logic [15:0] v);
    ccc_exp_t e;
    e = model;
    e.evt = '0;
    e.evt.set_mwl = 1'b1;
    e.mwl = v;
    send_ccc(e, i3c_standby_pkg::CccSetmwl, v[15:8], v[7:0], 1'b1);
  endtask

  task automatic rstact(input logic [7:0] a);
    ccc_exp_t e;
    e = model;
    e.evt = '0;
    e.evt.rst_act_valid = 1'b1;
    send_ccc(e, i3c_standby_pkg::CccRstact, a, 8'h00, 1'b0);
    check_value("rst_action_o", a, rst_action_o);
  endtask

  task automatic wait_rst(input logic esc, input logic level);
    int t;
    for (t = 0; t < Timeout && ((esc ? escalated_reset_o : peripheral_reset_o) != level); t++) begin
      @(negedge clk_i);
    end
    assert ((esc ? escalated_reset_o : peripheral_reset_o) == level)
      else report_failure("timeout waiting for a reset request output");
  endtask

  task automatic pulse_pattern();
    @(posedge clk_i);
    target_reset_pattern_i <= 1'b1;
    @(posedge clk_i);
    target_reset_pattern_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic pulse_done();
    @(posedge clk_i);
    peripheral_reset_done_i <= 1'b1;
    @(posedge clk_i);
    peripheral_reset_done_i <= 1'b0;
    @(negedge clk_i);
  endtask

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    bus_evt_i = '0;
    target_reset_pattern_i = 1'b0;
    dyn_addr_i = DynAddr;
    ibi_addr_i = 7'h35;
    ibi_word_i = '0;
    ibi_valid_i = 1'b0;
    tx_ready_i = 1'b1;
    peripheral_reset_done_i = 1'b0;
    lfsr_q = 32'h309b;
    errors = 0;
    gate_ibi = 1'b0;
    stall_q = 1'b0;
    apply_reset();

    private_write(DynAddr, 4, 1'b0);
    private_write(OtherAddr, 3, 1'b0);
    private_write(DynAddr, 1, 1'b0);
    wait_rx();

    enec_disec(1'b0, 8'h08);
    enec_disec(1'b1, 8'h09);
    setmwl(16'h1234);
    setmwl(16'h00ff);

    queue_ibi(0);
    wait_ibi();
    for (k = 0; k < 3; k++) begin
      queue_ibi(int'(rand_bits(6)));
      wait_ibi();
    end

    // Interrupt disabled, the queued IBI must wait for ENEC
    enec_disec(1'b0, 8'h01);
    gate_ibi = 1'b1;
    queue_ibi(5);
    repeat (20) @(negedge clk_i);
    gate_ibi = 1'b0;
    enec_disec(1'b1, 8'h01);
    wait_ibi();
    private_write(DynAddr, 3, 1'b1);
    wait_ibi();
    wait_rx();

    rstact(`I3C_RST_ACT_PERIPH);
    wait_rst(1'b0, 1'b1);
    check_value("escalated_reset_o", 0, escalated_reset_o);
    pulse_done();
    check_value("peripheral_reset_o", 0, peripheral_reset_o);
    pulse_pattern();
    check_value("peripheral_reset_o", 1, peripheral_reset_o);
    check_value("escalated_reset_o", 0, escalated_reset_o);
    pulse_done();
    check_value("peripheral_reset_o", 0, peripheral_reset_o);
    pulse_pattern();
    check_value("escalated_reset_o", 1, escalated_reset_o);
    // Escalation must survive a peripheral reset done
    pulse_done();
    repeat (10) begin
      check_value("escalated_reset_o", 1, escalated_reset_o);
      @(negedge clk_i);
    end

    apply_reset();
    rstact(`I3C_RST_ACT_ESCALATE);
    wait_rst(1'b1, 1'b1);
    check_value("peripheral_reset_o", 0, peripheral_reset_o);

    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: i3c_standby_ctrl.f
+incdir+design
design/i3c_standby_pkg.sv
design/frame_decoder.sv
design/ccc_decoder.sv
design/ibi_engine.sv
design/reset_action.sv
design/i3c_standby_ctrl.sv
verification/tb_i3c_standby_ctrl.sv

// File: Bender.yml
package:
  name: i3c_standby_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/i3c_standby_pkg.sv
      - design/frame_decoder.sv
      - design/ccc_decoder.sv
      - design/ibi_engine.sv
      - design/reset_action.sv
      - design/i3c_standby_ctrl.sv
      - target: test
        files:
          - verification/tb_i3c_standby_ctrl.sv
